// ==== logic/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// data and address width of the core.
`define XLEN 32

// address of the first instruction fetched after reset.
`define RESET_PC 32'h0000_0000

// number of architectural registers, x0 included.
`define REG_COUNT 32

`endif

// ==== logic/riscv_pkg.sv ====
`include "riscv_macros.svh"

package riscv_pkg;

    // base opcodes of the supported instruction classes.
    typedef enum logic [6:0] {
        op_i_type_l = 7'b0000011,
        op_i_type   = 7'b0010011,
        op_s_type   = 7'b0100011,
        op_r_type   = 7'b0110011,
        op_b_type   = 7'b1100011,
        op_j_type   = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_op_add = 3'b000,
        alu_op_sub = 3'b001,
        alu_op_or  = 3'b010,
        alu_op_and = 3'b011,
        alu_op_xor = 3'b100,
        alu_op_sll = 3'b101,
        alu_op_srl = 3'b110
    } alu_op_e;

    typedef enum logic {
        alu_src_reg     = 1'b0,
        alu_src_ext_imm = 1'b1
    } alu_src_e;

    typedef enum logic [1:0] {
        res_src_alu_out   = 2'b00,
        res_src_read_data = 2'b01,
        res_src_pc_plus_4 = 2'b10
    } result_src_e;

    typedef enum logic {
        pc_src_plus_4   = 1'b0,
        pc_src_plus_off = 1'b1
    } pc_src_e;

    // how the immediate bits are scattered in the instruction word.
    typedef enum logic [1:0] {
        imm_src_itype = 2'b00,
        imm_src_stype = 2'b01,
        imm_src_btype = 2'b10,
        imm_src_jtype = 2'b11
    } imm_src_e;

    // carry sits in bit 0 and negative in bit 3.
    typedef struct packed {
        logic negative;
        logic zero;
        logic overflow;
        logic carry;
    } alu_flags_t;

    typedef struct packed {
        logic        reg_we;
        logic        mem_we;
        alu_src_e    alu_src;
        result_src_e result_src;
        pc_src_e     pc_src;
        imm_src_e    imm_src;
        alu_op_e     alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_t;

    // everything the memory stage needs to finish one instruction.
    typedef struct packed {
        logic                           reg_we;
        logic                           mem_we;
        logic                           mem_rd;
        result_src_e                    result_src;
        logic [$clog2(`REG_COUNT)-1:0]  rd;
        logic [`XLEN-1:0]               alu_out;
        logic [`XLEN-1:0]               store_data;
        logic [`XLEN-1:0]               pc_plus_4;
        logic [`XLEN-1:0]               next_pc;
    } exec_t;

endpackage

// ==== logic/controller.sv ====
`timescale 1ns/1ps

// maps the opcode and function fields to the operation the ALU performs.
module alu_dec (
    input  riscv_pkg::opcode_e op,
    input  logic [2:0]         func3,
    input  logic [6:0]         func7,
    output riscv_pkg::alu_op_e alu_ctrl
);
    riscv_pkg::alu_op_e r_type_op;

    always_comb begin
        case (func3)
            3'b000: begin
                // sub is the only R-type here with a nonzero func7.
                r_type_op = (func7 == 7'b0) ? riscv_pkg::alu_op_add : riscv_pkg::alu_op_sub;
            end
            3'b110: r_type_op = riscv_pkg::alu_op_or;
            3'b111: r_type_op = riscv_pkg::alu_op_and;
            3'b100: r_type_op = riscv_pkg::alu_op_xor;
            3'b001: r_type_op = riscv_pkg::alu_op_sll;
            3'b101: r_type_op = riscv_pkg::alu_op_srl;
            default: r_type_op = riscv_pkg::alu_op_e'(3'bx);
        endcase
    end

    always_comb begin
        case (op)
            riscv_pkg::op_r_type:   alu_ctrl = r_type_op;
            riscv_pkg::op_i_type:   alu_ctrl = riscv_pkg::alu_op_add;
            riscv_pkg::op_i_type_l: alu_ctrl = riscv_pkg::alu_op_add;
            riscv_pkg::op_s_type:   alu_ctrl = riscv_pkg::alu_op_add;
            riscv_pkg::op_b_type:   alu_ctrl = riscv_pkg::alu_op_sub;
            default:                alu_ctrl = riscv_pkg::alu_op_e'(3'bx);
        endcase
    end
endmodule

// main control decoder. Branch outcome comes from the flags of rs1 - rs2.
module controller (
    input  logic [31:0]           instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t      ctrl
);
    riscv_pkg::opcode_e op;
    riscv_pkg::alu_op_e alu_op;
    riscv_pkg::pc_src_e pc_src_b_type;
    logic [2:0]         func3;

    assign op    = riscv_pkg::opcode_e'(instr[6:0]);
    assign func3 = instr[14:12];

    alu_dec u_alu_dec (
        .op       (op),
        .func3    (func3),
        .func7    (instr[31:25]),
        .alu_ctrl (alu_op)
    );

    // blt and bge look at the negative flag only.
    always_comb begin
        case (func3)
            3'b000: pc_src_b_type = alu_flags.zero ? riscv_pkg::pc_src_plus_off
                                                   : riscv_pkg::pc_src_plus_4;
            3'b001: pc_src_b_type = alu_flags.zero ? riscv_pkg::pc_src_plus_4
                                                   : riscv_pkg::pc_src_plus_off;
            3'b100: pc_src_b_type = alu_flags.negative ? riscv_pkg::pc_src_plus_off
                                                       : riscv_pkg::pc_src_plus_4;
            3'b101: pc_src_b_type = alu_flags.negative ? riscv_pkg::pc_src_plus_4
                                                       : riscv_pkg::pc_src_plus_off;
            default: pc_src_b_type = riscv_pkg::pc_src_e'(1'bx);
        endcase
    end

    // fields an instruction class does not use stay x.
    always_comb begin
        ctrl          = riscv_pkg::ctrl_t'('x);
        ctrl.alu_ctrl = alu_op;
        case (op)
            riscv_pkg::op_i_type_l: begin
                ctrl.reg_we     = 1'b1;
                ctrl.mem_we     = 1'b0;
                ctrl.alu_src    = riscv_pkg::alu_src_ext_imm;
                ctrl.result_src = riscv_pkg::res_src_read_data;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
                ctrl.imm_src    = riscv_pkg::imm_src_itype;
            end
            riscv_pkg::op_i_type: begin
                ctrl.reg_we     = 1'b1;
                ctrl.mem_we     = 1'b0;
                ctrl.alu_src    = riscv_pkg::alu_src_ext_imm;
                ctrl.result_src = riscv_pkg::res_src_alu_out;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
                ctrl.imm_src    = riscv_pkg::imm_src_itype;
            end
            riscv_pkg::op_s_type: begin
                ctrl.reg_we     = 1'b0;
                ctrl.mem_we     = 1'b1;
                ctrl.alu_src    = riscv_pkg::alu_src_ext_imm;
                ctrl.result_src = riscv_pkg::res_src_read_data;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
                ctrl.imm_src    = riscv_pkg::imm_src_stype;
            end
            riscv_pkg::op_r_type: begin
                ctrl.reg_we     = 1'b1;
                ctrl.mem_we     = 1'b0;
                ctrl.alu_src    = riscv_pkg::alu_src_reg;
                ctrl.result_src = riscv_pkg::res_src_alu_out;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
            end
            riscv_pkg::op_b_type: begin
                ctrl.reg_we     = 1'b0;
                ctrl.mem_we     = 1'b0;
                ctrl.alu_src    = riscv_pkg::alu_src_reg;
                ctrl.pc_src     = pc_src_b_type;
                ctrl.imm_src    = riscv_pkg::imm_src_btype;
            end
            riscv_pkg::op_j_type: begin
                ctrl.reg_we     = 1'b1;
                ctrl.mem_we     = 1'b0;
                ctrl.result_src = riscv_pkg::res_src_pc_plus_4;
                ctrl.pc_src     = riscv_pkg::pc_src_plus_off;
                ctrl.imm_src    = riscv_pkg::imm_src_jtype;
            end
            default: ;
        endcase
    end
endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module alu (
    input  logic [`XLEN-1:0]      a,
    input  logic [`XLEN-1:0]      b,
    input  riscv_pkg::alu_op_e    alu_ctrl,
    output logic [`XLEN-1:0]      result,
    output riscv_pkg::alu_flags_t flags
);
    logic             is_sub;
    logic             is_arith;
    logic [`XLEN-1:0] b_eff;
    logic [`XLEN:0]   sum;

    // subtraction is a + ~b + 1 so both share one adder.
    assign is_sub   = (alu_ctrl == riscv_pkg::alu_op_sub);
    assign is_arith = is_sub || (alu_ctrl == riscv_pkg::alu_op_add);
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, is_sub};

    always_comb begin
        case (alu_ctrl)
            riscv_pkg::alu_op_add: result = sum[`XLEN-1:0];
            riscv_pkg::alu_op_sub: result = sum[`XLEN-1:0];
            riscv_pkg::alu_op_or:  result = a | b;
            riscv_pkg::alu_op_and: result = a & b;
            riscv_pkg::alu_op_xor: result = a ^ b;
            riscv_pkg::alu_op_sll: result = a << b[$clog2(`XLEN)-1:0];
            riscv_pkg::alu_op_srl: result = a >> b[$clog2(`XLEN)-1:0];
            default:               result = 'x;
        endcase
    end

    // overflow when both adder inputs agree in sign and the sum does not.
    assign flags.carry    = is_arith && sum[`XLEN];
    assign flags.overflow = is_arith && (a[`XLEN-1] == b_eff[`XLEN-1])
                            && (sum[`XLEN-1] != a[`XLEN-1]);
    assign flags.zero     = (result == '0);
    assign flags.negative = result[`XLEN-1];
endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               done,
    input  logic [`XLEN-1:0]   next_pc,
    output logic               iwb_cyc,
    output logic               iwb_stb,
    output logic [`XLEN-1:0]   iwb_adr,
    input  logic [`XLEN-1:0]   iwb_dat_i,
    input  logic               iwb_ack,
    output logic               f_valid,
    output riscv_pkg::fetch_t  f_item
);
    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_wait_done
    } state_e;

    state_e           state;
    logic [`XLEN-1:0] pc;

    // the request is held straight from the state register until ack.
    assign iwb_cyc = (state == st_bus);
    assign iwb_stb = (state == st_bus);
    assign iwb_adr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            pc      <= `RESET_PC;
            f_valid <= 1'b0;
        end else begin
            f_valid <= 1'b0;
            case (state)
                st_idle: state <= st_bus;
                st_bus: begin
                    if (iwb_ack) begin
                        f_valid <= 1'b1;
                        state   <= st_wait_done;
                    end
                end
                st_wait_done: begin
                    // one instruction in flight, so wait for its writeback.
                    if (done) begin
                        pc    <= next_pc;
                        state <= st_bus;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_bus && iwb_ack) begin
            f_item.pc    <= pc;
            f_item.instr <= iwb_dat_i;
        end
    end
endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          f_valid,
    input  riscv_pkg::fetch_t             f_item,
    input  logic                          wb_we,
    input  logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    input  logic [`XLEN-1:0]              wb_data,
    output logic                          e_valid,
    output riscv_pkg::exec_t              e_item
);
    logic [`XLEN-1:0]              regs [`REG_COUNT];
    logic [`XLEN-1:0]              instr;
    logic [$clog2(`REG_COUNT)-1:0] rs1;
    logic [$clog2(`REG_COUNT)-1:0] rs2;
    logic [`XLEN-1:0]              rs1_val;
    logic [`XLEN-1:0]              rs2_val;
    logic [`XLEN-1:0]              imm_ext;
    logic [`XLEN-1:0]              src_b;
    logic [`XLEN-1:0]              alu_out;
    logic [`XLEN-1:0]              pc_plus_4;
    logic [`XLEN-1:0]              next_pc;
    riscv_pkg::ctrl_t              ctrl;
    riscv_pkg::alu_flags_t         flags;

    assign instr = f_item.instr;
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];

    // x0 is never written, so its entry is masked on read.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        case (ctrl.imm_src)
            riscv_pkg::imm_src_itype: imm_ext = {{20{instr[31]}}, instr[31:20]};
            riscv_pkg::imm_src_stype: imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscv_pkg::imm_src_btype: imm_ext = {{19{instr[31]}}, instr[31], instr[7],
                                                 instr[30:25], instr[11:8], 1'b0};
            riscv_pkg::imm_src_jtype: imm_ext = {{11{instr[31]}}, instr[31], instr[19:12],
                                                 instr[20], instr[30:21], 1'b0};
            default:                  imm_ext = 'x;
        endcase
    end

    controller u_controller (
        .instr     (instr),
        .alu_flags (flags),
        .ctrl      (ctrl)
    );

    assign src_b = (ctrl.alu_src == riscv_pkg::alu_src_ext_imm) ? imm_ext : rs2_val;

    alu u_alu (
        .a        (rs1_val),
        .b        (src_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_out),
        .flags    (flags)
    );

    assign pc_plus_4 = f_item.pc + 32'd4;
    assign next_pc   = (ctrl.pc_src == riscv_pkg::pc_src_plus_off) ? f_item.pc + imm_ext
                                                                   : pc_plus_4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= f_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (f_valid) begin
            e_item.reg_we     <= ctrl.reg_we;
            e_item.mem_we     <= ctrl.mem_we;
            e_item.mem_rd     <= ctrl.reg_we
                                 && (ctrl.result_src == riscv_pkg::res_src_read_data);
            e_item.result_src <= ctrl.result_src;
            e_item.rd         <= instr[11:7];
            e_item.alu_out    <= alu_out;
            e_item.store_data <= rs2_val;
            e_item.pc_plus_4  <= pc_plus_4;
            e_item.next_pc    <= next_pc;
        end
    end
endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module memory_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          e_valid,
    input  riscv_pkg::exec_t              e_item,
    output logic                          dwb_cyc,
    output logic                          dwb_stb,
    output logic                          dwb_we,
    output logic [`XLEN-1:0]              dwb_adr,
    output logic [`XLEN-1:0]              dwb_dat_o,
    input  logic [`XLEN-1:0]              dwb_dat_i,
    input  logic                          dwb_ack,
    output logic                          wb_we,
    output logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    output logic [`XLEN-1:0]              wb_data,
    output logic                          done,
    output logic [`XLEN-1:0]              next_pc
);
    typedef enum logic {
        st_idle,
        st_bus
    } state_e;

    state_e           state;
    riscv_pkg::exec_t item;
    riscv_pkg::exec_t src;
    logic             access;
    logic             finish;
    logic [`XLEN-1:0] result;

    assign dwb_cyc   = (state == st_bus);
    assign dwb_stb   = (state == st_bus);
    assign dwb_we    = (state == st_bus) && item.mem_we;
    assign dwb_adr   = item.alu_out;
    assign dwb_dat_o = item.store_data;

    // during a bus cycle the latched item is live, otherwise the incoming one.
    assign src    = (state == st_bus) ? item : e_item;
    assign access = e_item.mem_rd || e_item.mem_we;
    assign finish = (state == st_idle && e_valid && !access) || (state == st_bus && dwb_ack);

    always_comb begin
        case (src.result_src)
            riscv_pkg::res_src_alu_out:   result = src.alu_out;
            riscv_pkg::res_src_read_data: result = dwb_dat_i;
            riscv_pkg::res_src_pc_plus_4: result = src.pc_plus_4;
            default:                      result = 'x;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            done  <= finish;
            wb_we <= finish && src.reg_we;
            if (state == st_idle && e_valid && access) begin
                state <= st_bus;
            end else if (state == st_bus && dwb_ack) begin
                state <= st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && e_valid) begin
            item <= e_item;
        end
        if (finish) begin
            wb_rd   <= src.rd;
            wb_data <= result;
            next_pc <= src.next_pc;
        end
    end
endmodule

// ==== logic/riscv_core.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

// three stages with a single instruction passed along at a time.
module riscv_core (
    input  logic             clk,
    input  logic             rst_n,
    output logic             iwb_cyc,
    output logic             iwb_stb,
    output logic [`XLEN-1:0] iwb_adr,
    input  logic [`XLEN-1:0] iwb_dat_i,
    input  logic             iwb_ack,
    output logic             dwb_cyc,
    output logic             dwb_stb,
    output logic             dwb_we,
    output logic [`XLEN-1:0] dwb_adr,
    output logic [`XLEN-1:0] dwb_dat_o,
    input  logic [`XLEN-1:0] dwb_dat_i,
    input  logic             dwb_ack
);
    logic                          f_valid;
    riscv_pkg::fetch_t             f_item;
    logic                          e_valid;
    riscv_pkg::exec_t              e_item;
    logic                          wb_we;
    logic [$clog2(`REG_COUNT)-1:0] wb_rd;
    logic [`XLEN-1:0]              wb_data;
    logic                          done;
    logic [`XLEN-1:0]              next_pc;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .next_pc   (next_pc),
        .iwb_cyc   (iwb_cyc),
        .iwb_stb   (iwb_stb),
        .iwb_adr   (iwb_adr),
        .iwb_dat_i (iwb_dat_i),
        .iwb_ack   (iwb_ack),
        .f_valid   (f_valid),
        .f_item    (f_item)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .f_valid (f_valid),
        .f_item  (f_item),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .e_valid (e_valid),
        .e_item  (e_item)
    );

    memory_stage u_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .e_valid   (e_valid),
        .e_item    (e_item),
        .dwb_cyc   (dwb_cyc),
        .dwb_stb   (dwb_stb),
        .dwb_we    (dwb_we),
        .dwb_adr   (dwb_adr),
        .dwb_dat_o (dwb_dat_o),
        .dwb_dat_i (dwb_dat_i),
        .dwb_ack   (dwb_ack),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .done      (done),
        .next_pc   (next_pc)
    );
endmodule

// ==== dv/tb_riscv_core.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module tb_riscv_core;
    localparam logic [`XLEN-1:0] store_base = 32'h0000_0200;
    localparam logic [`XLEN-1:0] load_base  = 32'h0000_0100;
    localparam logic [`XLEN-1:0] stop_addr  = 32'h0000_03fc;
    localparam logic [31:0]      nop_word   = 32'h0000_0013;
    localparam logic [6:0]       opc_imm    = 7'b0010011;
    localparam logic [6:0]       opc_load   = 7'b0000011;

    logic             clk       = 1'b0;
    logic             rst_n     = 1'b0;
    logic             iwb_cyc;
    logic             iwb_stb;
    logic [`XLEN-1:0] iwb_adr;
    logic [`XLEN-1:0] iwb_dat_i = '0;
    logic             iwb_ack   = 1'b0;
    logic             dwb_cyc;
    logic             dwb_stb;
    logic             dwb_we;
    logic [`XLEN-1:0] dwb_adr;
    logic [`XLEN-1:0] dwb_dat_o;
    logic [`XLEN-1:0] dwb_dat_i = '0;
    logic             dwb_ack   = 1'b0;

    // each R-type row holds func7, func3 and the source registers of one operation.
    logic [6:0] r_f7  [7] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
    logic [2:0] r_f3  [7] = '{3'b000, 3'b000, 3'b110, 3'b111, 3'b100, 3'b001, 3'b101};
    int         r_rs1 [7] = '{1, 1, 1, 1, 1, 2, 2};
    int         r_rs2 [7] = '{2, 2, 2, 2, 2, 3, 3};

    // each branch condition has one taken row and one not-taken row.
    logic [2:0] br_f3  [8] = '{3'b000, 3'b000, 3'b001, 3'b001,
                               3'b100, 3'b100, 3'b101, 3'b101};
    int         br_rs1 [8] = '{1, 1, 1, 1, 2, 1, 1, 2};
    int         br_rs2 [8] = '{12, 2, 2, 12, 1, 2, 2, 1};

    logic [31:0] prog    [$];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] reg_ref [32];
    logic [31:0] dmem    [256];
    logic [31:0] rng       = 32'd44;
    logic [1:0]  i_wait    = '0;
    logic        i_busy    = 1'b0;
    logic [1:0]  d_wait    = '0;
    logic        d_busy    = 1'b0;
    logic        stop_seen = 1'b0;
    int          st_idx    = 0;
    int          errors    = 0;

    riscv_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .iwb_cyc   (iwb_cyc),
        .iwb_stb   (iwb_stb),
        .iwb_adr   (iwb_adr),
        .iwb_dat_i (iwb_dat_i),
        .iwb_ack   (iwb_ack),
        .dwb_cyc   (dwb_cyc),
        .dwb_stb   (dwb_stb),
        .dwb_we    (dwb_we),
        .dwb_adr   (dwb_adr),
        .dwb_dat_o (dwb_dat_o),
        .dwb_dat_i (dwb_dat_i),
        .dwb_ack   (dwb_ack)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // every data word differs with its byte address.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [2:0] f3,
                                          input logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [31:0] rs1,
                                          input logic [2:0] f3, input logic [31:0] rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [31:0] rs2,
                                          input logic [31:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] rtype_ref(input logic [2:0] f3, input logic [6:0] f7,
                                              input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return f7[5] ? x - y : x + y;
            3'b110:  return x | y;
            3'b111:  return x & y;
            3'b100:  return x ^ y;
            3'b001:  return x << y[4:0];
            3'b101:  return x >> y[4:0];
            default: return 'x;
        endcase
    endfunction

    task automatic check_addr(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_adr.push_back(addr);
        exp_dat.push_back(data);
    endtask

    task automatic load_imm(input int rd, input logic [31:0] value);
        emit(enc_i(value, 0, 3'b000, rd, opc_imm));
        reg_ref[rd] = value;
    endtask

    task automatic store_and_expect(input int rs2, input logic [31:0] off,
                                    input logic [31:0] data);
        emit(enc_s(off, rs2, 10));
        expect_store(store_base + off, data);
    endtask

    task automatic build_program();
        logic [31:0] off;
        logic [31:0] diff;
        logic [31:0] jal_pc;
        logic        taken;
        off = '0;
        load_imm(10, store_base);
        load_imm(1, 32'd1443);
        load_imm(2, 32'hffff_fed4);
        load_imm(3, 32'd5);
        load_imm(12, 32'd1443);
        for (int k = 0; k < 7; k++) begin
            emit(enc_r(r_f7[k], r_rs2[k], r_rs1[k], r_f3[k], 4));
            store_and_expect(4, off,
                             rtype_ref(r_f3[k], r_f7[k], reg_ref[r_rs1[k]], reg_ref[r_rs2[k]]));
            off += 4;
        end
        load_imm(11, load_base);
        emit(enc_i(4, 11, 3'b010, 5, opc_load));
        emit(enc_i(77, 5, 3'b000, 5, opc_imm));
        store_and_expect(5, off, fill_word(load_base + 4) + 32'd77);
        off += 4;
        emit(enc_i(12, 11, 3'b010, 6, opc_load));
        emit(enc_i(32'hffff_ffff, 6, 3'b000, 6, opc_imm));
        store_and_expect(6, off, fill_word(load_base + 12) - 32'd1);
        off += 4;
        load_imm(7, 32'h111);
        load_imm(8, 32'h222);
        // a taken branch skips the x7 store and lands on the x8 store.
        for (int k = 0; k < 8; k++) begin
            diff = reg_ref[br_rs1[k]] - reg_ref[br_rs2[k]];
            case (br_f3[k])
                3'b000:  taken = (diff == '0);
                3'b001:  taken = (diff != '0);
                3'b100:  taken = diff[31];
                default: taken = !diff[31];
            endcase
            emit(enc_b(8, br_rs2[k], br_rs1[k], br_f3[k]));
            emit(enc_s(off, 7, 10));
            if (!taken) begin
                expect_store(store_base + off, 32'h111);
            end
            off += 4;
            store_and_expect(8, off, 32'h222);
            off += 4;
        end
        jal_pc = prog.size() * 4;
        emit(enc_j(8, 9));
        emit(enc_s(off, 8, 10));
        off += 4;
        store_and_expect(9, off, jal_pc + 32'd4);
        emit(enc_s(stop_addr, 1, 0));
        expect_store(stop_addr, reg_ref[1]);
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = addr >> 2;
        return (idx < prog.size()) ? prog[idx] : nop_word;
    endfunction

    task automatic record_store(input logic [`XLEN-1:0] adr, input logic [`XLEN-1:0] dat);
        if (st_idx >= exp_adr.size()) begin
            $display("error: unexpected extra store of %h to address %h at t=%0t",
                     dat, adr, $time);
            errors++;
        end else begin
            check_addr("dwb_adr", exp_adr[st_idx], adr);
            check_data("dwb_dat_o", exp_dat[st_idx], dat);
            st_idx++;
        end
        if (adr == stop_addr) begin
            stop_seen = 1'b1;
        end
    endtask

    task automatic serve_ibus();
        if (iwb_ack) begin
            iwb_ack = 1'b0;
        end else if (iwb_cyc && iwb_stb) begin
            if (!i_busy) begin
                rng    = xorshift(rng);
                i_wait = rng[1:0];
                i_busy = 1'b1;
            end
            if (i_wait == 2'd0) begin
                iwb_ack   = 1'b1;
                iwb_dat_i = fetch_word(iwb_adr);
                i_busy    = 1'b0;
            end else begin
                i_wait = i_wait - 2'd1;
            end
        end
    endtask

    task automatic serve_dbus();
        logic [7:0] idx;
        idx = dwb_adr[9:2];
        if (dwb_ack) begin
            dwb_ack = 1'b0;
        end else if (dwb_cyc && dwb_stb) begin
            if (!d_busy) begin
                rng    = xorshift(rng);
                d_wait = rng[1:0];
                d_busy = 1'b1;
            end
            if (d_wait == 2'd0) begin
                dwb_ack = 1'b1;
                d_busy  = 1'b0;
                if (dwb_adr[31:10] != '0) begin
                    $display("error: data access outside the memory at %h", dwb_adr);
                    errors++;
                end
                if (dwb_we) begin
                    dmem[idx] = dwb_dat_o;
                    record_store(dwb_adr, dwb_dat_o);
                end else begin
                    dwb_dat_i = dmem[idx];
                end
            end else begin
                d_wait = d_wait - 2'd1;
            end
        end
    endtask

    // both slaves share one process so the random wait states come in a fixed order.
    always @(negedge clk) begin
        serve_ibus();
        serve_dbus();
    end

    initial begin
        build_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i * 4);
        end
        repeat (2) begin
            @(negedge clk);
            check_level("iwb_cyc", 1'b0, iwb_cyc);
            check_level("iwb_stb", 1'b0, iwb_stb);
            check_level("dwb_cyc", 1'b0, dwb_cyc);
            check_level("dwb_stb", 1'b0, dwb_stb);
            check_level("dwb_we", 1'b0, dwb_we);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_level("iwb_cyc", 1'b1, iwb_cyc);
        check_level("iwb_stb", 1'b1, iwb_stb);
        check_addr("iwb_adr", `RESET_PC, iwb_adr);
        check_level("dwb_cyc", 1'b0, dwb_cyc);
        check_level("dwb_stb", 1'b0, dwb_stb);
        check_level("dwb_we", 1'b0, dwb_we);
        wait (stop_seen);
        repeat (2) @(negedge clk);
        if (st_idx != exp_adr.size()) begin
            $display("error: only %0d of %0d expected stores were seen", st_idx, exp_adr.size());
            errors++;
        end
        $display("tb_riscv_core finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // an instruction needs at most 11 cycles with three wait states on both buses.
    initial begin
        @(posedge rst_n);
        #(prog.size() * 12 * 100);
        $display("error: the program did not reach its final store before the watchdog");
        $display("TB FAILED");
        $finish;
    end
endmodule

// ==== riscv_core.f ====
+incdir+logic
logic/riscv_pkg.sv
logic/controller.sv
logic/alu.sv
logic/fetch_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/riscv_core.sv
dv/tb_riscv_core.sv

// ==== Makefile ====
TOP  = tb_riscv_core
SRCS = $(shell grep -v '^+' riscv_core.f) logic/riscv_macros.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): riscv_core.f $(SRCS)
	verilator --binary --timing -j 0 --top-module $(TOP) -f riscv_core.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir
